// File: design/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Data and address width
`define RV_XLEN 32

// Architectural registers
`define RV_NREGS 32

// Register index width
`define RV_REG_AW 5

`endif

// File: design/rv32i_isa_pkg.sv
`include "rv_params.svh"

package rv32i_isa_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [31:0]           instr_t;
    typedef logic [`RV_REG_AW-1:0] reg_idx_t;

    // Major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_fence  = 7'b0001111,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    // Encoded as the branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic {
        a_sel_rs1,
        a_sel_pc
    } alu_a_sel_e;

    typedef enum logic [1:0] {
        b_sel_rs2,
        b_sel_i_imm,
        b_sel_u_imm,
        b_sel_const4
    } alu_b_sel_e;

    typedef enum logic {
        wb_sel_alu,
        wb_sel_pc4 // Link value of jumps
    } wb_sel_e;

endpackage

// File: design/rv32i_stage_pkg.sv
package rv32i_stage_pkg;

    typedef struct packed {
        rv32i_isa_pkg::alu_op_e    alu_op;
        rv32i_isa_pkg::cmp_op_e    cmp_op;
        rv32i_isa_pkg::alu_a_sel_e alu_a_sel;
        rv32i_isa_pkg::alu_b_sel_e alu_b_sel;
        logic                      is_branch;
        logic                      is_jal;
        logic                      is_jalr;
    } ex_ctrl_t;

    typedef struct packed {
        logic                   reg_write;
        rv32i_isa_pkg::wb_sel_e wb_sel;
        logic                   illegal;
    } wb_ctrl_t;

    typedef struct packed {
        logic                    valid;
        rv32i_isa_pkg::word_t    pc;
        rv32i_isa_pkg::reg_idx_t rs1;
        rv32i_isa_pkg::reg_idx_t rs2;
        rv32i_isa_pkg::word_t    rs1_value;
        rv32i_isa_pkg::word_t    rs2_value;
        rv32i_isa_pkg::word_t    imm;   // I, B or J format, sign extended
        rv32i_isa_pkg::word_t    u_imm;
        rv32i_isa_pkg::reg_idx_t rd;
        ex_ctrl_t                ex_ctrl;
        wb_ctrl_t                wb_ctrl;
    } id_ex_t;

    typedef struct packed {
        logic                    valid;
        rv32i_isa_pkg::word_t    pc;
        rv32i_isa_pkg::reg_idx_t rd;
        rv32i_isa_pkg::word_t    alu_out;
        rv32i_isa_pkg::word_t    pc_plus4;
        logic                    br_taken;
        rv32i_isa_pkg::word_t    br_target; // Zero when not taken
        wb_ctrl_t                wb_ctrl;
    } ex_wb_t;

endpackage

// File: design/rv_regfile.sv
`include "rv_params.svh"

module rv_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv32i_isa_pkg::reg_idx_t raddr1,
    input  rv32i_isa_pkg::reg_idx_t raddr2,
    output rv32i_isa_pkg::word_t    rdata1,
    output rv32i_isa_pkg::word_t    rdata2,
    input  logic                    we,
    input  rv32i_isa_pkg::reg_idx_t waddr,
    input  rv32i_isa_pkg::word_t    wdata
);

    rv32i_isa_pkg::word_t regs [`RV_NREGS];

    // Write-first, x0 hardwired
    function automatic rv32i_isa_pkg::word_t read_port(input rv32i_isa_pkg::reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (we && addr == waddr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

// File: design/rv_alu.sv
module rv_alu (
    input  rv32i_isa_pkg::alu_op_e alu_op,
    input  rv32i_isa_pkg::word_t   a,
    input  rv32i_isa_pkg::word_t   b,
    output rv32i_isa_pkg::word_t   alu_out
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            rv32i_isa_pkg::alu_add:    alu_out = a + b;
            rv32i_isa_pkg::alu_sub:    alu_out = a - b;
            rv32i_isa_pkg::alu_sll:    alu_out = a << shamt;
            rv32i_isa_pkg::alu_slt:    alu_out = rv32i_isa_pkg::word_t'($signed(a) < $signed(b));
            rv32i_isa_pkg::alu_sltu:   alu_out = rv32i_isa_pkg::word_t'(a < b);
            rv32i_isa_pkg::alu_xor:    alu_out = a ^ b;
            rv32i_isa_pkg::alu_srl:    alu_out = a >> shamt;
            rv32i_isa_pkg::alu_sra:    alu_out = $signed(a) >>> shamt; // Sign fill
            rv32i_isa_pkg::alu_or:     alu_out = a | b;
            rv32i_isa_pkg::alu_and:    alu_out = a & b;
            rv32i_isa_pkg::alu_pass_b: alu_out = b; // LUI
            default:                   alu_out = '0;
        endcase
    end

endmodule

// File: design/id_stage.sv
module id_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  rv32i_isa_pkg::instr_t   instr,
    input  rv32i_isa_pkg::word_t    pc,
    output rv32i_isa_pkg::reg_idx_t rs1_addr,
    output rv32i_isa_pkg::reg_idx_t rs2_addr,
    input  rv32i_isa_pkg::word_t    rs1_data,
    input  rv32i_isa_pkg::word_t    rs2_data,
    output rv32i_stage_pkg::id_ex_t id_ex
);

    rv32i_isa_pkg::opcode_e    opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    rv32i_isa_pkg::word_t      i_imm, b_imm, j_imm, u_imm, imm;
    rv32i_stage_pkg::ex_ctrl_t ex_ctrl;
    rv32i_stage_pkg::wb_ctrl_t wb_ctrl;
    rv32i_stage_pkg::id_ex_t   id_next;

    // Shared by OP and OP-IMM, alt picks SUB or SRA
    function automatic rv32i_isa_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv32i_isa_pkg::alu_sub : rv32i_isa_pkg::alu_add;
            3'b001:  return rv32i_isa_pkg::alu_sll;
            3'b010:  return rv32i_isa_pkg::alu_slt;
            3'b011:  return rv32i_isa_pkg::alu_sltu;
            3'b100:  return rv32i_isa_pkg::alu_xor;
            3'b101:  return alt ? rv32i_isa_pkg::alu_sra : rv32i_isa_pkg::alu_srl;
            3'b110:  return rv32i_isa_pkg::alu_or;
            default: return rv32i_isa_pkg::alu_and;
        endcase
    endfunction

    assign opcode   = rv32i_isa_pkg::opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Immediates
    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};

    // *****************************************************************
    // Control decode
    // *****************************************************************
    always_comb begin
        ex_ctrl.alu_op    = rv32i_isa_pkg::alu_add;
        ex_ctrl.cmp_op    = rv32i_isa_pkg::cmp_op_e'(funct3);
        ex_ctrl.alu_a_sel = rv32i_isa_pkg::a_sel_rs1;
        ex_ctrl.alu_b_sel = rv32i_isa_pkg::b_sel_rs2;
        ex_ctrl.is_branch = 1'b0;
        ex_ctrl.is_jal    = 1'b0;
        ex_ctrl.is_jalr   = 1'b0;
        wb_ctrl.reg_write = 1'b1;
        wb_ctrl.wb_sel    = rv32i_isa_pkg::wb_sel_alu;
        wb_ctrl.illegal   = 1'b0;
        imm               = i_imm;
        case (opcode)
            rv32i_isa_pkg::op_lui: begin
                ex_ctrl.alu_op    = rv32i_isa_pkg::alu_pass_b;
                ex_ctrl.alu_b_sel = rv32i_isa_pkg::b_sel_u_imm;
            end
            rv32i_isa_pkg::op_auipc: begin
                ex_ctrl.alu_a_sel = rv32i_isa_pkg::a_sel_pc;
                ex_ctrl.alu_b_sel = rv32i_isa_pkg::b_sel_u_imm;
            end
            rv32i_isa_pkg::op_jal: begin
                ex_ctrl.is_jal    = 1'b1;
                ex_ctrl.alu_a_sel = rv32i_isa_pkg::a_sel_pc;
                ex_ctrl.alu_b_sel = rv32i_isa_pkg::b_sel_const4;
                wb_ctrl.wb_sel    = rv32i_isa_pkg::wb_sel_pc4;
                imm               = j_imm;
            end
            rv32i_isa_pkg::op_jalr: begin
                ex_ctrl.is_jalr   = 1'b1;
                ex_ctrl.alu_a_sel = rv32i_isa_pkg::a_sel_pc;
                ex_ctrl.alu_b_sel = rv32i_isa_pkg::b_sel_const4;
                wb_ctrl.wb_sel    = rv32i_isa_pkg::wb_sel_pc4;
                wb_ctrl.illegal   = funct3 != 3'b000;
            end
            rv32i_isa_pkg::op_branch: begin
                ex_ctrl.is_branch = 1'b1;
                wb_ctrl.reg_write = 1'b0;
                wb_ctrl.illegal   = funct3[2:1] == 2'b01; // No compare at 010, 011
                imm               = b_imm;
            end
            rv32i_isa_pkg::op_imm: begin
                ex_ctrl.alu_b_sel = rv32i_isa_pkg::b_sel_i_imm;
                ex_ctrl.alu_op    = arith_op(funct3, funct3 == 3'b101 && instr[30]);
            end
            rv32i_isa_pkg::op_reg: begin
                ex_ctrl.alu_op  = arith_op(funct3, instr[30]);
                // Only base funct7 values, M extension falls out here
                wb_ctrl.illegal = !(funct7 == 7'h00 ||
                                   (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            default: wb_ctrl.illegal = 1'b1; // Loads, stores, FENCE, SYSTEM
        endcase
        if (wb_ctrl.illegal) begin
            wb_ctrl.reg_write = 1'b0;
            ex_ctrl.is_branch = 1'b0;
            ex_ctrl.is_jalr   = 1'b0;
        end
        if (instr[11:7] == '0) begin
            wb_ctrl.reg_write = 1'b0;
        end
    end

    always_comb begin
        id_next.valid     = instr_valid;
        id_next.pc        = pc;
        id_next.rs1       = rs1_addr;
        id_next.rs2       = rs2_addr;
        id_next.rs1_value = rs1_data;
        id_next.rs2_value = rs2_data;
        id_next.imm       = imm;
        id_next.u_imm     = u_imm;
        id_next.rd        = instr[11:7];
        id_next.ex_ctrl   = ex_ctrl;
        id_next.wb_ctrl   = wb_ctrl;
    end

    always_ff @(posedge clk) begin
        id_ex <= id_next;
        if (!rst_n) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

// File: design/ex_stage.sv
module ex_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv32i_stage_pkg::id_ex_t id_ex,
    input  logic                    fwd_we,
    input  rv32i_isa_pkg::reg_idx_t fwd_rd,
    input  rv32i_isa_pkg::word_t    fwd_value,
    output rv32i_stage_pkg::ex_wb_t ex_wb
);

    rv32i_stage_pkg::ex_ctrl_t ex_ctrl;
    rv32i_isa_pkg::word_t      rs1_v, rs2_v;
    rv32i_isa_pkg::word_t      alu_a, alu_b, alu_out;
    rv32i_isa_pkg::word_t      pc_plus4, br_target;
    logic                      cmp_true;
    logic                      br_taken;
    rv32i_stage_pkg::ex_wb_t   ex_next;

    // Older instruction in ex_wb wins over the decode-time read
    function automatic rv32i_isa_pkg::word_t forward(input rv32i_isa_pkg::reg_idx_t idx,
                                                     input rv32i_isa_pkg::word_t    value);
        if (fwd_we && fwd_rd != '0 && fwd_rd == idx) begin
            return fwd_value;
        end
        return value;
    endfunction

    assign ex_ctrl = id_ex.ex_ctrl;

    always_comb begin
        rs1_v = forward(id_ex.rs1, id_ex.rs1_value);
        rs2_v = forward(id_ex.rs2, id_ex.rs2_value);
    end

    // *****************************************************************
    // ALU operand muxes
    // *****************************************************************
    always_comb begin
        case (ex_ctrl.alu_a_sel)
            rv32i_isa_pkg::a_sel_pc: alu_a = id_ex.pc;
            default:                 alu_a = rs1_v;
        endcase
        case (ex_ctrl.alu_b_sel)
            rv32i_isa_pkg::b_sel_i_imm:  alu_b = id_ex.imm;
            rv32i_isa_pkg::b_sel_u_imm:  alu_b = id_ex.u_imm;
            rv32i_isa_pkg::b_sel_const4: alu_b = 'd4;
            default:                     alu_b = rs2_v;
        endcase
    end

    rv_alu alu (
        .alu_op  (ex_ctrl.alu_op),
        .a       (alu_a),
        .b       (alu_b),
        .alu_out (alu_out)
    );

    // Branch compare
    always_comb begin
        case (ex_ctrl.cmp_op)
            rv32i_isa_pkg::cmp_beq:  cmp_true = rs1_v == rs2_v;
            rv32i_isa_pkg::cmp_bne:  cmp_true = rs1_v != rs2_v;
            rv32i_isa_pkg::cmp_blt:  cmp_true = $signed(rs1_v) < $signed(rs2_v);
            rv32i_isa_pkg::cmp_bge:  cmp_true = $signed(rs1_v) >= $signed(rs2_v);
            rv32i_isa_pkg::cmp_bltu: cmp_true = rs1_v < rs2_v;
            rv32i_isa_pkg::cmp_bgeu: cmp_true = rs1_v >= rs2_v;
            default:                 cmp_true = 1'b0;
        endcase
    end

    always_comb begin
        pc_plus4 = id_ex.pc + 'd4;
        br_taken = ex_ctrl.is_jal || ex_ctrl.is_jalr || (ex_ctrl.is_branch && cmp_true);
        if (ex_ctrl.is_jalr) begin
            br_target = (rs1_v + id_ex.imm) & ~rv32i_isa_pkg::word_t'(1);
        end else begin
            br_target = id_ex.pc + id_ex.imm;
        end
        if (!br_taken) begin
            br_target = '0;
        end
    end

    always_comb begin
        ex_next.valid     = id_ex.valid;
        ex_next.pc        = id_ex.pc;
        ex_next.rd        = id_ex.rd;
        ex_next.alu_out   = alu_out;
        ex_next.pc_plus4  = pc_plus4;
        ex_next.br_taken  = br_taken;
        ex_next.br_target = br_target;
        ex_next.wb_ctrl   = id_ex.wb_ctrl;
    end

    always_ff @(posedge clk) begin
        ex_wb <= ex_next;
        if (!rst_n) begin
            ex_wb.valid <= 1'b0;
        end
    end

endmodule

// File: design/wb_stage.sv
module wb_stage (
    input  rv32i_stage_pkg::ex_wb_t ex_wb,
    output logic                    rf_we,
    output rv32i_isa_pkg::reg_idx_t rf_waddr,
    output rv32i_isa_pkg::word_t    rf_wdata,
    output logic                    retire_valid,
    output rv32i_isa_pkg::word_t    retire_pc,
    output rv32i_isa_pkg::reg_idx_t retire_rd,
    output rv32i_isa_pkg::word_t    retire_value,
    output logic                    retire_reg_write,
    output logic                    retire_illegal,
    output logic                    retire_br_taken,
    output rv32i_isa_pkg::word_t    retire_br_target
);

    rv32i_isa_pkg::word_t wb_value;

    always_comb begin
        if (ex_wb.wb_ctrl.wb_sel == rv32i_isa_pkg::wb_sel_pc4) begin
            wb_value = ex_wb.pc_plus4; // Link
        end else begin
            wb_value = ex_wb.alu_out;
        end
    end

    // Bubbles write nothing
    assign rf_we    = ex_wb.valid && ex_wb.wb_ctrl.reg_write;
    assign rf_waddr = ex_wb.rd;
    assign rf_wdata = wb_value;

    assign retire_valid     = ex_wb.valid;
    assign retire_pc        = ex_wb.pc;
    assign retire_rd        = ex_wb.rd;
    assign retire_value     = wb_value;
    assign retire_reg_write = rf_we;
    assign retire_illegal   = ex_wb.valid && ex_wb.wb_ctrl.illegal;
    assign retire_br_taken  = ex_wb.br_taken;
    assign retire_br_target = ex_wb.br_target;

endmodule

// File: design/rv_core.sv
module rv_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  rv32i_isa_pkg::instr_t   instr,
    input  rv32i_isa_pkg::word_t    pc,
    output logic                    retire_valid,
    output rv32i_isa_pkg::word_t    retire_pc,
    output rv32i_isa_pkg::reg_idx_t retire_rd,
    output rv32i_isa_pkg::word_t    retire_value,
    output logic                    retire_reg_write,
    output logic                    retire_illegal,
    output logic                    retire_br_taken,
    output rv32i_isa_pkg::word_t    retire_br_target
);

    rv32i_stage_pkg::id_ex_t id_ex;
    rv32i_stage_pkg::ex_wb_t ex_wb;
    rv32i_isa_pkg::reg_idx_t rs1_addr, rs2_addr;
    rv32i_isa_pkg::word_t    rs1_data, rs2_data;
    logic                    rf_we;
    rv32i_isa_pkg::reg_idx_t rf_waddr;
    rv32i_isa_pkg::word_t    rf_wdata;

    id_stage u_id (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .id_ex       (id_ex)
    );

    // Write port doubles as the forward source
    ex_stage u_ex (
        .clk       (clk),
        .rst_n     (rst_n),
        .id_ex     (id_ex),
        .fwd_we    (rf_we),
        .fwd_rd    (rf_waddr),
        .fwd_value (rf_wdata),
        .ex_wb     (ex_wb)
    );

    wb_stage u_wb (
        .ex_wb            (ex_wb),
        .rf_we            (rf_we),
        .rf_waddr         (rf_waddr),
        .rf_wdata         (rf_wdata),
        .retire_valid     (retire_valid),
        .retire_pc        (retire_pc),
        .retire_rd        (retire_rd),
        .retire_value     (retire_value),
        .retire_reg_write (retire_reg_write),
        .retire_illegal   (retire_illegal),
        .retire_br_taken  (retire_br_taken),
        .retire_br_target (retire_br_target)
    );

    rv_regfile u_rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

// File: verif/rv_core_assertions.sv
module rv_core_assertions (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic retire_valid,
    input logic retire_illegal,
    input logic retire_reg_write
);

    // Fixed two-cycle latency, no stalls
    property retire_latency;
        @(posedge clk) disable iff (!rst_n)
            retire_valid == $past(instr_valid, 2);
    endproperty

    property illegal_no_write;
        @(posedge clk) disable iff (!rst_n)
            retire_illegal |-> !retire_reg_write;
    endproperty

    property quiet_in_reset;
        @(posedge clk) (!rst_n && !$past(rst_n)) |-> !retire_valid;
    endproperty

    assert property (retire_latency)
        else $error("retire_valid did not follow instr_valid by two cycles");
    assert property (illegal_no_write)
        else $error("illegal instruction retired with a register write");
    assert property (quiet_in_reset)
        else $error("retire_valid high during reset");

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clk              (clk),
    .rst_n            (rst_n),
    .instr_valid      (instr_valid),
    .retire_valid     (retire_valid),
    .retire_illegal   (retire_illegal),
    .retire_reg_write (retire_reg_write)
);

// File: verif/rv_core_tb.sv
module rv_core_tb;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] value;
        logic        reg_write;
        logic        illegal;
        logic        br_taken;
        logic [31:0] br_target;
    } retire_t;

    localparam logic [6:0] opc_lui   = 7'h37;
    localparam logic [6:0] opc_auipc = 7'h17;
    localparam logic [6:0] opc_imm   = 7'h13;
    localparam logic [6:0] opc_jalr  = 7'h67;
    localparam logic [6:0] opc_load  = 7'h03;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_value;
    logic        retire_reg_write;
    logic        retire_illegal;
    logic        retire_br_taken;
    logic [31:0] retire_br_target;

    logic [31:0] shadow [32];  // Architectural state in program order
    retire_t     expq [$];
    logic [31:0] next_pc;
    integer      seed;
    int          errors;
    int          start_errors;
    int          tests_run;
    string       cur_test;

    rv_core dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .pc               (pc),
        .retire_valid     (retire_valid),
        .retire_pc        (retire_pc),
        .retire_rd        (retire_rd),
        .retire_value     (retire_value),
        .retire_reg_write (retire_reg_write),
        .retire_illegal   (retire_illegal),
        .retire_br_taken  (retire_br_taken),
        .retire_br_target (retire_br_target)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // *******************************************************************
    // Instruction encoders
    // *******************************************************************
    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] off, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    // *******************************************************************
    // Reference model
    // *******************************************************************
    function automatic logic [31:0] arith(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b, input logic alt);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic retire_t predict(input logic [31:0] w, input logic [31:0] at_pc);
        retire_t     r;
        logic [31:0] a, b, i_imm, b_imm, j_imm, u_imm;
        logic        cond;
        a     = shadow[w[19:15]];
        b     = shadow[w[24:20]];
        i_imm = {{20{w[31]}}, w[31:20]};
        b_imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        j_imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        u_imm = {w[31:12], 12'b0};
        cond  = 1'b0;
        r           = '0;
        r.pc        = at_pc;
        r.rd        = w[11:7];
        r.reg_write = 1'b1;
        case (w[6:0])
            7'h37: r.value = u_imm;
            7'h17: r.value = at_pc + u_imm;
            7'h6f: begin
                r.value     = at_pc + 4;
                r.br_taken  = 1'b1;
                r.br_target = at_pc + j_imm;
            end
            7'h67: begin
                r.value     = at_pc + 4;
                r.br_taken  = 1'b1;
                r.br_target = (a + i_imm) & 32'hffff_fffe;
            end
            7'h63: begin
                case (w[14:12])
                    3'b000:  cond = a == b;
                    3'b001:  cond = a != b;
                    3'b100:  cond = $signed(a) < $signed(b);
                    3'b101:  cond = $signed(a) >= $signed(b);
                    3'b110:  cond = a < b;
                    default: cond = a >= b;
                endcase
                r.reg_write = 1'b0;
                r.br_taken  = cond;
                r.br_target = cond ? at_pc + b_imm : 32'h0;
            end
            7'h13: r.value = arith(w[14:12], a, i_imm, w[14:12] == 3'b101 && w[30]);
            7'h33: r.value = arith(w[14:12], a, b, w[30]);
            default: begin
                r.reg_write = 1'b0;
                r.illegal   = 1'b1;
            end
        endcase
        if (w[11:7] == 5'd0) begin
            r.reg_write = 1'b0;
        end
        if (r.reg_write) begin
            shadow[w[11:7]] = r.value;
        end
        return r;
    endfunction

    function automatic string format_retire(input retire_t r);
        return $sformatf("pc=%h rd=%0d val=%h we=%b ill=%b tk=%b tgt=%h", r.pc, r.rd,
                         r.value, r.reg_write, r.illegal, r.br_taken, r.br_target);
    endfunction

    // Retires are compared in order against the predictions
    always @(negedge clk) begin
        retire_t expected;
        retire_t actual;
        if (rst_n && retire_valid) begin
            if (expq.size() == 0) begin
                $display("%s: retire at pc %h with no instruction outstanding",
                         cur_test, retire_pc);
                errors++;
            end else begin
                expected = expq.pop_front();
                actual   = {retire_pc, retire_rd, retire_value, retire_reg_write,
                            retire_illegal, retire_br_taken, retire_br_target};
                if (!expected.reg_write) begin
                    expected.value = '0;
                    actual.value   = '0;
                end
                if (actual !== expected) begin
                    $display("[ERROR] %s: expected %s, actual %s", cur_test,
                             format_retire(expected), format_retire(actual));
                    errors++;
                end
            end
        end
    end

    // *******************************************************************
    // Drivers
    // *******************************************************************
    task automatic issue(input logic [31:0] w);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        pc          <= next_pc;
        expq.push_back(predict(w, next_pc));
        next_pc = next_pc + 4;
    endtask

    task automatic bubble();
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] upper;
        upper = value[31:12] + {19'b0, value[11]}; // ADDI sign-extends the low part
        issue(encode_u(upper, rd, opc_lui));
        issue(encode_i(value[11:0], rd, 3'b000, rd, opc_imm));
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        start_errors = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        int waited;
        bubble();
        waited = 0;
        while (expq.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (expq.size() != 0) begin
            $display("%s: timed out with %0d instructions never retired",
                     cur_test, expq.size());
            errors++;
            expq.delete();
        end
        $display("%s finished with %0d errors", cur_test, errors - start_errors);
    endtask

    // *******************************************************************
    // Directed tests
    // *******************************************************************
    task automatic test_reg_ops();
        logic [31:0] v;
        start_test("reg_ops");
        v = $random(seed);
        load_reg(5'd1, v | 32'h8000_0000); // Negative, so SRA fills ones
        v = $random(seed);
        load_reg(5'd2, v);
        for (int f = 0; f < 8; f++) begin
            issue(encode_r(7'h00, 5'd2, 5'd1, f[2:0], 5'(f + 3)));
        end
        issue(encode_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd11)); // SUB
        issue(encode_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd12)); // SRA
        issue(encode_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd13)); // SLT reversed
        finish_test();
    endtask

    task automatic test_imm_ops();
        logic [31:0] v;
        start_test("imm_ops");
        v = $random(seed);
        load_reg(5'd1, v | 32'h8000_0000);
        issue(encode_i(12'hf9c, 5'd1, 3'b000, 5'd3, opc_imm)); // ADDI -100
        issue(encode_i(12'h800, 5'd1, 3'b010, 5'd4, opc_imm));
        issue(encode_i(12'hfff, 5'd1, 3'b011, 5'd5, opc_imm));
        issue(encode_i(12'h5a5, 5'd1, 3'b100, 5'd6, opc_imm));
        issue(encode_i(12'hf0f, 5'd1, 3'b110, 5'd7, opc_imm));
        issue(encode_i(12'h0ff, 5'd1, 3'b111, 5'd8, opc_imm));
        issue(encode_i({7'h00, 5'd7}, 5'd1, 3'b001, 5'd9, opc_imm));
        issue(encode_i({7'h00, 5'd13}, 5'd1, 3'b101, 5'd10, opc_imm));
        issue(encode_i({7'h20, 5'd13}, 5'd1, 3'b101, 5'd11, opc_imm)); // SRAI
        issue(encode_i({7'h20, 5'd31}, 5'd1, 3'b101, 5'd12, opc_imm));
        finish_test();
    endtask

    task automatic test_hazards();
        start_test("hazards");
        issue(encode_i(12'h007, 5'd0, 3'b000, 5'd5, opc_imm));
        issue(encode_r(7'h00, 5'd5, 5'd5, 3'b000, 5'd6));  // Distance one
        issue(encode_r(7'h00, 5'd5, 5'd6, 3'b000, 5'd7));  // One and two
        bubble();
        issue(encode_r(7'h20, 5'd6, 5'd7, 3'b000, 5'd8));
        bubble();
        bubble();
        issue(encode_r(7'h00, 5'd7, 5'd8, 3'b100, 5'd9));
        issue(encode_i({7'h00, 5'd3}, 5'd9, 3'b001, 5'd9, opc_imm));
        issue(encode_r(7'h00, 5'd8, 5'd9, 3'b000, 5'd10));
        finish_test();
    endtask

    task automatic test_branches();
        logic [2:0] conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        start_test("branches");
        load_reg(5'd1, 32'hffff_fffb);
        load_reg(5'd2, 32'd3);
        for (int i = 0; i < 6; i++) begin
            issue(encode_b(13'h0010, 5'd2, 5'd1, conds[i]));
            issue(encode_b(13'h1ff8, 5'd1, 5'd1, conds[i])); // Backward
        end
        finish_test();
    endtask

    task automatic test_jumps();
        start_test("jumps");
        issue(encode_j(21'h000100, 5'd1));
        load_reg(5'd3, 32'h0000_1235);
        issue(encode_i(12'h006, 5'd3, 3'b000, 5'd2, opc_jalr)); // Odd target
        issue(encode_i(12'hffd, 5'd3, 3'b000, 5'd4, opc_jalr));
        issue(encode_u(20'hdead0, 5'd5, opc_lui));
        issue(encode_u(20'h00012, 5'd6, opc_auipc));
        issue(encode_j(21'h1ffff0, 5'd0));
        finish_test();
    endtask

    task automatic test_illegal();
        start_test("illegal");
        issue(encode_i(12'h004, 5'd1, 3'b010, 5'd7, opc_load)); // LW
        issue(32'h0000_0073);                                   // ECALL
        issue(encode_i(12'h037, 5'd0, 3'b000, 5'd0, opc_imm));
        load_reg(5'd0, 32'h1234_5678);
        issue(encode_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd9));
        issue(encode_r(7'h00, 5'd7, 5'd0, 3'b000, 5'd10));
        finish_test();
    endtask

    initial begin
        seed         = 32'h7068;
        errors       = 0;
        start_errors = 0;
        tests_run    = 0;
        next_pc      = 32'h0000_1000;
        cur_test     = "reset";
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        test_reg_ops();
        test_imm_ops();
        test_hazards();
        test_branches();
        test_jumps();
        test_illegal();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/rv32i_isa_pkg.sv
design/rv32i_stage_pkg.sv
design/rv_regfile.sv
design/rv_alu.sv
design/id_stage.sv
design/ex_stage.sv
design/wb_stage.sv
design/rv_core.sv
verif/rv_core_assertions.sv
verif/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run rv_core_tb with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f project.f --top-module rv_core_tb -Mdir obj_dir; then
    echo "Verilator compile failed"
    exit 1
fi

if ! ./obj_dir/Vrv_core_tb > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
